// File: Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := hier_interco_tb
FILELIST  := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/hier_interco_properties.sv
// Assertion checker for the root remap stage, attached to root_id_remap by bind from the testbench
`include "interco_macros.svh"

module hier_interco_properties import interco_pkg::*; (
  input logic    clk_i,
  input logic    rst_n_i,
  input logic    ar_valid_i,
  input logic    ar_ready_i,
  input addr_t   ar_addr_i,
  input mst_id_t ar_id_i,
  input logic    r_valid_i,
  input logic    r_ready_i
);

  logic       ar_fire;
  logic       r_fire;
  // Reads sent to memory and not yet answered
  logic [3:0] outstanding_q;

  assign ar_fire = ar_valid_i && ar_ready_i;
  assign r_fire  = r_valid_i && r_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      outstanding_q <= 4'd0;
    end else begin
      outstanding_q <= outstanding_q + 4'(ar_fire) - 4'(r_fire);
    end
  end

  // Payload holds until the memory takes it
  ar_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_addr_i) && $stable(ar_id_i))
    else $error("master ar payload changed before its handshake");

  pool_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    outstanding_q <= 4'(`ID_POOL_DEPTH))
    else $error("more master reads outstanding than the ID pool holds");

  reset_idle: assert property (@(posedge clk_i) !rst_n_i |=> !ar_valid_i)
    else $error("master ar_valid high out of reset");

endmodule

// File: dv/hier_interco_tb.sv
// Self-checking testbench that runs a stimulus table through the read interconnect and a memory model
`include "interco_macros.svh"

module hier_interco_tb import interco_pkg::*; ();

  localparam int NUM_ENTRIES = 48;
  localparam int SINGLE_HI   = 4;
  localparam int B2B_HI      = 20;
  localparam int STALL_HI    = 32;
  // Spill registers, node registers and the root register
  localparam int PIPE_DEPTH  = `NUM_SLV_PORTS + `NUM_NODES + 1;
  localparam logic [31:0] DATA_MASK = 32'hA5A5_5A5A;

  logic                          clk_i;
  logic                          rst_n_i;
  logic    [`NUM_SLV_PORTS-1:0]  slv_ar_valid_i;
  addr_t   [`NUM_SLV_PORTS-1:0]  slv_ar_addr_i;
  slv_id_t [`NUM_SLV_PORTS-1:0]  slv_ar_id_i;
  logic    [`NUM_SLV_PORTS-1:0]  slv_r_ready_i;
  logic    [`NUM_SLV_PORTS-1:0]  slv_ar_ready_o;
  logic    [`NUM_SLV_PORTS-1:0]  slv_r_valid_o;
  data_t   [`NUM_SLV_PORTS-1:0]  slv_r_data_o;
  slv_id_t [`NUM_SLV_PORTS-1:0]  slv_r_id_o;
  logic                          mst_ar_valid_o;
  addr_t                         mst_ar_addr_o;
  mst_id_t                       mst_ar_id_o;
  logic                          mst_r_ready_o;
  logic                          mst_ar_ready_i;
  logic                          mst_r_valid_i;
  data_t                         mst_r_data_i;
  mst_id_t                       mst_r_id_i;

  // Stimulus table with one row per read
  int      tbl_port  [NUM_ENTRIES];
  addr_t   tbl_addr  [NUM_ENTRIES];
  slv_id_t tbl_id    [NUM_ENTRIES];
  logic    tbl_stall [NUM_ENTRIES];
  data_t   tbl_data  [NUM_ENTRIES];

  // Expected {id, data} per port in issue order
  logic [`SLV_ID_WIDTH+`DATA_WIDTH-1:0] exp_q [`NUM_SLV_PORTS][$];

  // Memory model state
  addr_t   mem_addr_q [$];
  mst_id_t mem_id_q   [$];
  int      mem_due_q  [$];
  logic    mem_hold;
  logic    rand_rready;

  logic [31:0] rng_state = 32'h241a341f;
  int          error_cnt = 0;
  int          check_cnt = 0;
  int          rsp_cnt   = 0;
  int          accepted_cnt;

  hier_interco_top u_hier_interco_top (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .slv_ar_valid_i (slv_ar_valid_i),
    .slv_ar_addr_i  (slv_ar_addr_i),
    .slv_ar_id_i    (slv_ar_id_i),
    .slv_r_ready_i  (slv_r_ready_i),
    .slv_ar_ready_o (slv_ar_ready_o),
    .slv_r_valid_o  (slv_r_valid_o),
    .slv_r_data_o   (slv_r_data_o),
    .slv_r_id_o     (slv_r_id_o),
    .mst_ar_valid_o (mst_ar_valid_o),
    .mst_ar_addr_o  (mst_ar_addr_o),
    .mst_ar_id_o    (mst_ar_id_o),
    .mst_r_ready_o  (mst_r_ready_o),
    .mst_ar_ready_i (mst_ar_ready_i),
    .mst_r_valid_i  (mst_r_valid_i),
    .mst_r_data_i   (mst_r_data_i),
    .mst_r_id_i     (mst_r_id_i)
  );

  bind root_id_remap hier_interco_properties u_hier_interco_properties (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .ar_valid_i (mst_ar_valid_o),
    .ar_ready_i (mst_ar_ready_i),
    .ar_addr_i  (mst_ar_addr_o),
    .ar_id_i    (mst_ar_id_o),
    .r_valid_i  (mst_r_valid_i),
    .r_ready_i  (mst_r_ready_o)
  );

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic int pending_count();
    int total;
    total = 0;
    for (int p = 0; p < `NUM_SLV_PORTS; p++) begin
      total += exp_q[p].size();
    end
    return total;
  endfunction

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  task automatic build_table();
    logic [31:0] r;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      r            = next_rand();
      tbl_port[i]  = i % `NUM_SLV_PORTS;
      tbl_addr[i]  = {r[31:2], 2'b00};
      tbl_id[i]    = r[1:0];
      tbl_stall[i] = (i >= B2B_HI) && (i < STALL_HI);
      tbl_data[i]  = {r[31:2], 2'b00} ^ DATA_MASK;
    end
  endtask

  // Entered on a rising edge and keeps valid up between back-to-back entries
  task automatic issue_port(input int p, input int lo, input int hi);
    for (int idx = lo; idx < hi; idx++) begin
      if (tbl_port[idx] == p) begin
        slv_ar_valid_i[p] <= 1'b1;
        slv_ar_addr_i[p]  <= tbl_addr[idx];
        slv_ar_id_i[p]    <= tbl_id[idx];
        do begin
          @(posedge clk_i);
        end while (!slv_ar_ready_o[p]);
        exp_q[p].push_back({tbl_id[idx], tbl_data[idx]});
        accepted_cnt++;
      end
    end
    slv_ar_valid_i[p] <= 1'b0;
  endtask

  task automatic wait_drain();
    do begin
      @(posedge clk_i);
    end while (pending_count() != 0);
  endtask

  task automatic run_concurrent(input int lo, input int hi);
    accepted_cnt = 0;
    if (tbl_stall[lo]) begin
      mem_hold <= 1'b1;
    end
    fork
      issue_port(0, lo, hi);
      issue_port(1, lo, hi);
      issue_port(2, lo, hi);
      issue_port(3, lo, hi);
      begin
        // Memory opens only once every pipeline slot is taken
        if (tbl_stall[lo]) begin
          do begin
            @(posedge clk_i);
          end while (accepted_cnt < PIPE_DEPTH);
          mem_hold <= 1'b0;
        end
      end
    join
    wait_drain();
  endtask

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////

  initial begin
    logic [31:0] r;
    logic        ar_wait;
    addr_t       ar_addr_prev;
    mst_id_t     ar_id_prev;
    int          cycle;
    int          outstanding;
    mst_ar_ready_i <= 1'b0;
    mst_r_valid_i  <= 1'b0;
    mst_r_data_i   <= '0;
    mst_r_id_i     <= '0;
    ar_wait     = 1'b0;
    cycle       = 0;
    outstanding = 0;
    forever begin
      @(posedge clk_i);
      if (rst_n_i) begin
        if (ar_wait) begin
          check_cnt++;
          if (!mst_ar_valid_o) begin
            error_cnt++;
            $display("Master read request withdrawn before its handshake");
          end else if (mst_ar_addr_o != ar_addr_prev) begin
            error_cnt++;
            $display("FAIL mst_ar_addr_o held: exp 0x%h got 0x%h", ar_addr_prev, mst_ar_addr_o);
          end else if (mst_ar_id_o != ar_id_prev) begin
            error_cnt++;
            $display("FAIL mst_ar_id_o held: exp 0x%h got 0x%h", ar_id_prev, mst_ar_id_o);
          end
        end
        ar_wait      = mst_ar_valid_o && !mst_ar_ready_i;
        ar_addr_prev = mst_ar_addr_o;
        ar_id_prev   = mst_ar_id_o;
        if (mst_ar_valid_o && mst_ar_ready_i) begin
          r = next_rand();
          mem_addr_q.push_back(mst_ar_addr_o);
          mem_id_q.push_back(mst_ar_id_o);
          mem_due_q.push_back(cycle + int'(r % 32'd6));
          outstanding++;
        end
        if (mst_r_valid_i && mst_r_ready_o) begin
          void'(mem_addr_q.pop_front());
          void'(mem_id_q.pop_front());
          void'(mem_due_q.pop_front());
          outstanding--;
        end
        check_cnt++;
        if (outstanding > `ID_POOL_DEPTH) begin
          error_cnt++;
          $display("FAIL outstanding reads: limit 0x%h got 0x%h", `ID_POOL_DEPTH, outstanding);
        end
        r = next_rand();
        mst_ar_ready_i <= !mem_hold && (r[1:0] != 2'b00);
        // In-order answers where the head waits out its delay
        if (mem_addr_q.size() != 0 && cycle >= mem_due_q[0]) begin
          mst_r_valid_i <= 1'b1;
          mst_r_data_i  <= mem_addr_q[0] ^ DATA_MASK;
          mst_r_id_i    <= mem_id_q[0];
        end else begin
          mst_r_valid_i <= 1'b0;
        end
      end
      cycle++;
    end
  end

  ////////////////////////////////////////
  // Response checker
  ////////////////////////////////////////

  initial begin
    logic [`SLV_ID_WIDTH+`DATA_WIDTH-1:0] exp;
    logic [`SLV_ID_WIDTH+`DATA_WIDTH-1:0] got;
    logic [`SLV_ID_WIDTH+`DATA_WIDTH-1:0] held_val [`NUM_SLV_PORTS];
    logic [`NUM_SLV_PORTS-1:0]            held;
    logic [31:0]                          r;
    slv_r_ready_i <= '1;
    held = '0;
    forever begin
      @(posedge clk_i);
      if (rst_n_i) begin
        for (int p = 0; p < `NUM_SLV_PORTS; p++) begin
          got = {slv_r_id_o[p], slv_r_data_o[p]};
          if (held[p]) begin
            check_cnt++;
            if (!slv_r_valid_o[p]) begin
              error_cnt++;
              $display("Response on port %0d withdrawn before its handshake", p);
            end else if (slv_r_data_o[p] != held_val[p][`DATA_WIDTH-1:0]) begin
              error_cnt++;
              $display("FAIL slv_r_data_o[%0d] held: exp 0x%h got 0x%h",
                       p, held_val[p][`DATA_WIDTH-1:0], slv_r_data_o[p]);
            end else if (slv_r_id_o[p] !=
                         held_val[p][`SLV_ID_WIDTH+`DATA_WIDTH-1:`DATA_WIDTH]) begin
              error_cnt++;
              $display("FAIL slv_r_id_o[%0d] held: exp 0x%h got 0x%h",
                       p, held_val[p][`SLV_ID_WIDTH+`DATA_WIDTH-1:`DATA_WIDTH], slv_r_id_o[p]);
            end
          end
          held[p]     = slv_r_valid_o[p] && !slv_r_ready_i[p];
          held_val[p] = got;
          if (slv_r_valid_o[p] && slv_r_ready_i[p]) begin
            if (exp_q[p].size() == 0) begin
              error_cnt++;
              $display("Unexpected response on port %0d with no read outstanding", p);
            end else begin
              exp = exp_q[p].pop_front();
              rsp_cnt++;
              check_cnt++;
              if (slv_r_data_o[p] != exp[`DATA_WIDTH-1:0]) begin
                error_cnt++;
                $display("FAIL slv_r_data_o[%0d]: exp 0x%h got 0x%h",
                         p, exp[`DATA_WIDTH-1:0], slv_r_data_o[p]);
              end
              check_cnt++;
              if (slv_r_id_o[p] != exp[`SLV_ID_WIDTH+`DATA_WIDTH-1:`DATA_WIDTH]) begin
                error_cnt++;
                $display("FAIL slv_r_id_o[%0d]: exp 0x%h got 0x%h",
                         p, exp[`SLV_ID_WIDTH+`DATA_WIDTH-1:`DATA_WIDTH], slv_r_id_o[p]);
              end
            end
          end
        end
      end
      r = next_rand();
      if (rand_rready) begin
        slv_r_ready_i <= r[`NUM_SLV_PORTS-1:0] | r[2*`NUM_SLV_PORTS-1:`NUM_SLV_PORTS];
      end else begin
        slv_r_ready_i <= '1;
      end
    end
  end

  ////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////

  initial begin
    rst_n_i        <= 1'b0;
    slv_ar_valid_i <= '0;
    slv_ar_addr_i  <= '0;
    slv_ar_id_i    <= '0;
    mem_hold       <= 1'b0;
    rand_rready    <= 1'b0;
    build_table();
    repeat (16) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    check_cnt++;
    if (mst_ar_valid_o !== 1'b0 || slv_r_valid_o !== '0 || slv_ar_ready_o !== '1) begin
      error_cnt++;
      $display("FAIL idle after reset: mst_ar_valid_o 0x%h slv_r_valid_o 0x%h",
               mst_ar_valid_o, slv_r_valid_o);
      $display("FAIL idle after reset: slv_ar_ready_o 0x%h", slv_ar_ready_o);
    end
    // One read at a time on each port
    for (int i = 0; i < SINGLE_HI; i++) begin
      issue_port(tbl_port[i], i, i + 1);
      wait_drain();
    end
    run_concurrent(SINGLE_HI, B2B_HI);
    run_concurrent(B2B_HI, STALL_HI);
    rand_rready <= 1'b1;
    run_concurrent(STALL_HI, NUM_ENTRIES);
    rand_rready <= 1'b0;
    // Quiet tail to catch stray responses
    repeat (PIPE_DEPTH) @(posedge clk_i);
    check_cnt++;
    if (rsp_cnt != NUM_ENTRIES || pending_count() != 0) begin
      error_cnt++;
      $display("Received %0d responses for %0d reads", rsp_cnt, NUM_ENTRIES);
    end
    $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    repeat (NUM_ENTRIES * 200) @(posedge clk_i);
    $display("Timeout after %0d cycles with %0d reads still pending",
             NUM_ENTRIES * 200, pending_count());
    $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
    $display("TB FAILED");
    $finish;
  end

endmodule

// File: sources.f
+incdir+src
src/interco_pkg.sv
src/rd_chan_if.sv
src/slv_port_spill.sv
src/rd_mux_node.sv
src/root_id_remap.sv
src/hier_interco_top.sv
dv/hier_interco_properties.sv
dv/hier_interco_tb.sv

// File: src/hier_interco_top.sv
// Top of the read interconnect, joining the spill stage, the mux nodes and the root remapper
`include "interco_macros.svh"

module hier_interco_top import interco_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  // Core side
  input  logic    [`NUM_SLV_PORTS-1:0] slv_ar_valid_i,
  input  addr_t   [`NUM_SLV_PORTS-1:0] slv_ar_addr_i,
  input  slv_id_t [`NUM_SLV_PORTS-1:0] slv_ar_id_i,
  input  logic    [`NUM_SLV_PORTS-1:0] slv_r_ready_i,
  output logic    [`NUM_SLV_PORTS-1:0] slv_ar_ready_o,
  output logic    [`NUM_SLV_PORTS-1:0] slv_r_valid_o,
  output data_t   [`NUM_SLV_PORTS-1:0] slv_r_data_o,
  output slv_id_t [`NUM_SLV_PORTS-1:0] slv_r_id_o,
  // Memory side
  output logic                         mst_ar_valid_o,
  output addr_t                        mst_ar_addr_o,
  output mst_id_t                      mst_ar_id_o,
  output logic                         mst_r_ready_o,
  input  logic                         mst_ar_ready_i,
  input  logic                         mst_r_valid_i,
  input  data_t                        mst_r_data_i,
  input  mst_id_t                      mst_r_id_i
);

  // Per-core channels after the spill registers
  rd_chan_if port_if [`NUM_SLV_PORTS] ();
  // One channel per node output
  rd_chan_if node_if [`NUM_NODES] ();

  slv_port_spill u_slv_port_spill (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .slv_ar_valid_i (slv_ar_valid_i),
    .slv_ar_addr_i  (slv_ar_addr_i),
    .slv_ar_id_i    (slv_ar_id_i),
    .slv_r_ready_i  (slv_r_ready_i),
    .slv_ar_ready_o (slv_ar_ready_o),
    .slv_r_valid_o  (slv_r_valid_o),
    .slv_r_data_o   (slv_r_data_o),
    .slv_r_id_o     (slv_r_id_o),
    .ports_o        (port_if)
  );

  ////////////////////////////////////////
  // Node level
  ////////////////////////////////////////

  // Each node serves RADIX neighbouring ports
  for (genvar n = 0; n < `NUM_NODES; n++) begin : gen_node
    rd_mux_node u_rd_mux_node (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .in_a_i  (port_if[n * `RADIX]),
      .in_b_i  (port_if[n * `RADIX + 1]),
      .out_o   (node_if[n])
    );
  end

  ////////////////////////////////////////
  // Root
  ////////////////////////////////////////

  root_id_remap u_root_id_remap (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .node_a_i       (node_if[0]),
    .node_b_i       (node_if[1]),
    .mst_ar_valid_o (mst_ar_valid_o),
    .mst_ar_addr_o  (mst_ar_addr_o),
    .mst_ar_id_o    (mst_ar_id_o),
    .mst_r_ready_o  (mst_r_ready_o),
    .mst_ar_ready_i (mst_ar_ready_i),
    .mst_r_valid_i  (mst_r_valid_i),
    .mst_r_data_i   (mst_r_data_i),
    .mst_r_id_i     (mst_r_id_i)
  );

endmodule

// File: src/interco_macros.svh
// Fixed sizing of the read interconnect, included by the package and by RTL that needs counts
`ifndef INTERCO_MACROS_SVH
`define INTERCO_MACROS_SVH

// Tree shape
`define NUM_SLV_PORTS 4
`define RADIX 2
`define NUM_NODES 2

// Bus widths
`define ADDR_WIDTH 32
`define DATA_WIDTH 32

// ID widths along the path
`define SLV_ID_WIDTH 2
// Slave ID plus one port-select bit
`define NODE_ID_WIDTH 3
// Node ID plus one node-select bit
`define ROOT_ID_WIDTH 4
`define MST_ID_WIDTH 2

// Master ID pool, also the outstanding read limit
`define ID_POOL_DEPTH 4

`endif

// File: src/interco_pkg.sv
// Shared bus and ID types for the read interconnect, imported by every RTL block
`include "interco_macros.svh"

package interco_pkg;

  typedef logic [`ADDR_WIDTH-1:0]   addr_t;
  typedef logic [`DATA_WIDTH-1:0]   data_t;
  typedef logic [`SLV_ID_WIDTH-1:0] slv_id_t;
  typedef logic [`MST_ID_WIDTH-1:0] mst_id_t;

  ////////////////////////////////////////
  // Node level ID
  ////////////////////////////////////////

  // Port select sits above the core's own ID
  typedef struct packed {
    logic    port_sel;
    slv_id_t slv_id;
  } node_id_s;

  typedef union packed {
    logic [`NODE_ID_WIDTH-1:0] raw;
    node_id_s                  fields;
  } node_id_u;

  ////////////////////////////////////////
  // Root level ID
  ////////////////////////////////////////

  typedef struct packed {
    logic     node_sel;
    node_id_u node_id;
  } root_id_s;

  // Raw form goes into the remap table
  typedef union packed {
    logic [`ROOT_ID_WIDTH-1:0] raw;
    root_id_s                  fields;
  } root_id_u;

endpackage

// File: src/rd_chan_if.sv
// One read address channel plus its read-data channel, used between interconnect stages
interface rd_chan_if import interco_pkg::*; ();

  // Address channel
  logic     ar_valid;
  logic     ar_ready;
  addr_t    ar_addr;
  node_id_u ar_id;

  // Read-data channel
  logic     r_valid;
  logic     r_ready;
  data_t    r_data;
  node_id_u r_id;

  // Requesting side
  modport mst (
    output ar_valid,
    output ar_addr,
    output ar_id,
    output r_ready,
    input  ar_ready,
    input  r_valid,
    input  r_data,
    input  r_id
  );

  // Responding side
  modport slv (
    input  ar_valid,
    input  ar_addr,
    input  ar_id,
    input  r_ready,
    output ar_ready,
    output r_valid,
    output r_data,
    output r_id
  );

endinterface

// File: src/rd_mux_node.sv
// Two-input read mux node, tags each request with its input index and steers responses back
module rd_mux_node import interco_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_n_i,
  rd_chan_if.slv in_a_i,
  rd_chan_if.slv in_b_i,
  rd_chan_if.mst out_o
);

  logic     out_full_q;
  addr_t    out_addr_q;
  node_id_u out_id_q;
  // Low means input A wins a tie
  logic     rr_q;

  logic     can_accept;
  logic     grant_a;
  logic     grant_b;
  addr_t    req_addr;
  node_id_u req_id;
  node_id_u rsp_id;
  logic     rsp_sel;

  ////////////////////////////////////////
  // Address channel
  ////////////////////////////////////////

  assign can_accept = !out_full_q || out_o.ar_ready;

  assign grant_a = can_accept && in_a_i.ar_valid && (!in_b_i.ar_valid || !rr_q);
  assign grant_b = can_accept && in_b_i.ar_valid && (!in_a_i.ar_valid || rr_q);

  assign in_a_i.ar_ready = grant_a;
  assign in_b_i.ar_ready = grant_b;

  // Prepend the winning index to the core ID
  always_comb begin
    req_id.fields.port_sel = grant_b;
    if (grant_b) begin
      req_addr             = in_b_i.ar_addr;
      req_id.fields.slv_id = in_b_i.ar_id.fields.slv_id;
    end else begin
      req_addr             = in_a_i.ar_addr;
      req_id.fields.slv_id = in_a_i.ar_id.fields.slv_id;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_full_q <= 1'b0;
      rr_q       <= 1'b0;
    end else begin
      if (grant_a || grant_b) begin
        out_full_q <= 1'b1;
        // Other input gets priority next time
        rr_q       <= grant_a;
      end else if (out_o.ar_ready) begin
        out_full_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant_a || grant_b) begin
      out_addr_q <= req_addr;
      out_id_q   <= req_id;
    end
  end

  assign out_o.ar_valid = out_full_q;
  assign out_o.ar_addr  = out_addr_q;
  assign out_o.ar_id    = out_id_q;

  ////////////////////////////////////////
  // Read-data channel
  ////////////////////////////////////////

  assign rsp_sel = out_o.r_id.fields.port_sel;

  // Strip the select bit before handing the ID back
  always_comb begin
    rsp_id.fields.port_sel = 1'b0;
    rsp_id.fields.slv_id   = out_o.r_id.fields.slv_id;
  end

  assign in_a_i.r_valid = out_o.r_valid && !rsp_sel;
  assign in_b_i.r_valid = out_o.r_valid && rsp_sel;
  assign in_a_i.r_data  = out_o.r_data;
  assign in_b_i.r_data  = out_o.r_data;
  assign in_a_i.r_id    = rsp_id;
  assign in_b_i.r_id    = rsp_id;

  assign out_o.r_ready = rsp_sel ? in_b_i.r_ready : in_a_i.r_ready;

endmodule

// File: src/root_id_remap.sv
// Root stage that arbitrates the nodes and maps their wide IDs onto the small master ID pool
`include "interco_macros.svh"

module root_id_remap import interco_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  rd_chan_if.slv  node_a_i,
  rd_chan_if.slv  node_b_i,
  output logic    mst_ar_valid_o,
  output addr_t   mst_ar_addr_o,
  output mst_id_t mst_ar_id_o,
  output logic    mst_r_ready_o,
  input  logic    mst_ar_ready_i,
  input  logic    mst_r_valid_i,
  input  data_t   mst_r_data_i,
  input  mst_id_t mst_r_id_i
);

  // Address register
  logic     ar_full_q;
  addr_t    ar_addr_q;
  mst_id_t  ar_id_q;
  logic     rr_q;

  // ID pool, one bit per master ID, high when free
  logic [`ID_POOL_DEPTH-1:0] id_free_q;
  logic [`ID_POOL_DEPTH-1:0] id_free_d;
  root_id_u                  id_table_q [`ID_POOL_DEPTH];
  mst_id_t                   free_id;
  logic                      id_avail;

  logic     can_accept;
  logic     grant_a;
  logic     grant_b;
  addr_t    req_addr;
  root_id_u req_id;

  // Response register
  logic     r_full_q;
  data_t    r_data_q;
  root_id_u r_id_q;
  logic     rsp_ready;
  logic     mst_r_fire;

  ////////////////////////////////////////
  // ID allocation
  ////////////////////////////////////////

  // Lowest free ID wins
  always_comb begin
    free_id = '0;
    for (int k = `ID_POOL_DEPTH - 1; k >= 0; k--) begin
      if (id_free_q[k]) begin
        free_id = mst_id_t'(k);
      end
    end
  end

  assign id_avail = |id_free_q;

  always_comb begin
    id_free_d = id_free_q;
    if (grant_a || grant_b) begin
      id_free_d[free_id] = 1'b0;
    end
    if (mst_r_fire) begin
      id_free_d[mst_r_id_i] = 1'b1;
    end
  end

  ////////////////////////////////////////
  // Address channel
  ////////////////////////////////////////

  // Stall the nodes while the pool is empty
  assign can_accept = id_avail && (!ar_full_q || mst_ar_ready_i);

  assign grant_a = can_accept && node_a_i.ar_valid && (!node_b_i.ar_valid || !rr_q);
  assign grant_b = can_accept && node_b_i.ar_valid && (!node_a_i.ar_valid || rr_q);

  assign node_a_i.ar_ready = grant_a;
  assign node_b_i.ar_ready = grant_b;

  assign req_addr   = grant_b ? node_b_i.ar_addr : node_a_i.ar_addr;
  assign req_id.raw = {grant_b, grant_b ? node_b_i.ar_id.raw : node_a_i.ar_id.raw};

  assign mst_ar_valid_o = ar_full_q;
  assign mst_ar_addr_o  = ar_addr_q;
  assign mst_ar_id_o    = ar_id_q;

  ////////////////////////////////////////
  // Read-data channel
  ////////////////////////////////////////

  assign rsp_ready     = r_id_q.fields.node_sel ? node_b_i.r_ready : node_a_i.r_ready;
  assign mst_r_ready_o = !r_full_q || rsp_ready;
  assign mst_r_fire    = mst_r_valid_i && mst_r_ready_o;

  assign node_a_i.r_valid = r_full_q && !r_id_q.fields.node_sel;
  assign node_b_i.r_valid = r_full_q && r_id_q.fields.node_sel;
  assign node_a_i.r_data  = r_data_q;
  assign node_b_i.r_data  = r_data_q;
  assign node_a_i.r_id    = r_id_q.fields.node_id;
  assign node_b_i.r_id    = r_id_q.fields.node_id;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ar_full_q <= 1'b0;
      rr_q      <= 1'b0;
      id_free_q <= '1;
      r_full_q  <= 1'b0;
    end else begin
      id_free_q <= id_free_d;
      if (grant_a || grant_b) begin
        ar_full_q <= 1'b1;
        rr_q      <= grant_a;
      end else if (mst_ar_ready_i) begin
        ar_full_q <= 1'b0;
      end
      if (mst_r_fire) begin
        r_full_q <= 1'b1;
      end else if (rsp_ready) begin
        r_full_q <= 1'b0;
      end
    end
  end

  // Table holds the original wide ID per master ID
  always_ff @(posedge clk_i) begin
    if (grant_a || grant_b) begin
      ar_addr_q           <= req_addr;
      ar_id_q             <= free_id;
      id_table_q[free_id] <= req_id;
    end
    if (mst_r_fire) begin
      r_data_q <= mst_r_data_i;
      r_id_q   <= id_table_q[mst_r_id_i];
    end
  end

endmodule

// File: src/slv_port_spill.sv
// Input stage that registers each core's read request and turns flat ports into interfaces
`include "interco_macros.svh"

module slv_port_spill import interco_pkg::*; (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic    [`NUM_SLV_PORTS-1:0]        slv_ar_valid_i,
  input  addr_t   [`NUM_SLV_PORTS-1:0]        slv_ar_addr_i,
  input  slv_id_t [`NUM_SLV_PORTS-1:0]        slv_ar_id_i,
  input  logic    [`NUM_SLV_PORTS-1:0]        slv_r_ready_i,
  output logic    [`NUM_SLV_PORTS-1:0]        slv_ar_ready_o,
  output logic    [`NUM_SLV_PORTS-1:0]        slv_r_valid_o,
  output data_t   [`NUM_SLV_PORTS-1:0]        slv_r_data_o,
  output slv_id_t [`NUM_SLV_PORTS-1:0]        slv_r_id_o,
  rd_chan_if.mst                              ports_o [`NUM_SLV_PORTS]
);

  for (genvar i = 0; i < `NUM_SLV_PORTS; i++) begin : gen_port
    logic    full_q;
    addr_t   addr_q;
    slv_id_t id_q;
    logic    accept;

    // Free slot, or the held request leaves this cycle
    assign slv_ar_ready_o[i] = !full_q || ports_o[i].ar_ready;
    assign accept            = slv_ar_valid_i[i] && slv_ar_ready_o[i];

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        full_q <= 1'b0;
      end else if (accept) begin
        full_q <= 1'b1;
      end else if (ports_o[i].ar_ready) begin
        full_q <= 1'b0;
      end
    end

    always_ff @(posedge clk_i) begin
      if (accept) begin
        addr_q <= slv_ar_addr_i[i];
        id_q   <= slv_ar_id_i[i];
      end
    end

    assign ports_o[i].ar_valid = full_q;
    assign ports_o[i].ar_addr  = addr_q;
    // Zero-extend the core ID into the node-wide field
    assign ports_o[i].ar_id.raw = {{(`NODE_ID_WIDTH - `SLV_ID_WIDTH){1'b0}}, id_q};

    // Responses pass straight through
    assign slv_r_valid_o[i]   = ports_o[i].r_valid;
    assign slv_r_data_o[i]    = ports_o[i].r_data;
    assign slv_r_id_o[i]      = ports_o[i].r_id.fields.slv_id;
    assign ports_o[i].r_ready = slv_r_ready_i[i];
  end

endmodule
